//--- hw/dbg_pkg.sv
// Shared debug types; fixed to a 16-bit CPU address and 8-bit data, opcodes above 08 are unknown
package dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Packet opcodes and frontend states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [7:0]
  {
    ECHO           = 8'h00,
    CPU_MEM_RD     = 8'h01,
    CPU_MEM_WR     = 8'h02,
    DBG_BRK        = 8'h03,
    DBG_RUN        = 8'h04,
    CPU_REG_RD     = 8'h05,
    CPU_REG_WR     = 8'h06,
    QUERY_DBG_BRK  = 8'h07,
    QUERY_ERR_CODE = 8'h08
  } dbg_op_e;

  typedef enum logic [2:0] {RUN, DECODE, HDR, PAYLOAD, WAIT} fe_state_e;

  // Error code bits, bit 0 reserved and always zero
  localparam int ERR_UNKNOWN_OP = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles between blocks
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    dbg_op_e     op;
    logic [15:0] addr;  // Register select in the low bits for register ops
    logic [15:0] cnt;
  } dbg_cmd_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } tx_req_t;         // One reply byte offered to the merge

  typedef struct packed {
    logic [15:0] addr;
    logic        r_nw;
    logic [7:0]  dout;
  } cpu_bus_t;

  typedef struct packed {
    logic [3:0] sel;
    logic       wr;
    logic [7:0] dout;
  } dbgreg_t;

endpackage

//--- hw/dbg_frontend.sv
// Header bytes arrive low byte first; brk is seen only while running, the error flag clears on reset only
module dbg_frontend
(
  input  logic              clk,
  input  logic              rst,
  input  logic [7:0]        rx_data,
  input  logic              rx_empty,
  output logic              rd_en,
  input  logic              brk,
  output logic              cmd_go,
  output dbg_pkg::dbg_cmd_t cmd,
  output logic              pl_valid,
  output logic [7:0]        pl_data,
  input  logic              pl_take,
  input  logic              bus_done,
  input  logic              reply_done,
  output logic              in_break,
  output logic [7:0]        err_code
);
  import dbg_pkg::*;

  fe_state_e   state;
  dbg_cmd_t    cmd_q;        // Command under assembly
  logic [1:0]  hdr_idx;      // Next header byte, 0 and 1 addr, 2 and 3 cnt
  logic [1:0]  hdr_last;     // Index of the final header byte
  logic [15:0] pl_left;      // Payload bytes still to pop
  logic        err_unknown;
  logic [15:0] hdr_cnt;
  dbg_op_e     rx_op;

  assign rx_op   = dbg_op_e'(rx_data);
  assign hdr_cnt = (hdr_idx == 2'd3) ? {rx_data, cmd_q.cnt[7:0]} : cmd_q.cnt;  // Count with byte in flight
  assign cmd     = cmd_q;
  assign pl_data = rx_data;
  // Held off during cmd_go so the engines see the new opcode first
  assign pl_valid = (state == PAYLOAD) && !rx_empty && !cmd_go;

  always_comb
  begin
    case (state)
      RUN:         rd_en = !rx_empty && !brk;  // A break request wins over the FIFO
      DECODE, HDR: rd_en = !rx_empty;
      PAYLOAD:     rd_en = pl_valid && pl_take;
      default:     rd_en = 1'b0;               // Engine busy
    endcase
    err_code                 = 8'h00;
    err_code[ERR_UNKNOWN_OP] = err_unknown;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= RUN;
      in_break    <= 1'b0;
      err_unknown <= 1'b0;
      cmd_go      <= 1'b0;
      hdr_idx     <= 2'd0;
      hdr_last    <= 2'd0;
      pl_left     <= 16'd0;
    end
    else
    begin
      cmd_go <= 1'b0;  // One-cycle pulse
      case (state)
        RUN:
          if (brk)
          begin
            state    <= DECODE;   // CPU asked for a break
            in_break <= 1'b1;
          end
          else if (rd_en)
          begin
            cmd_q.op <= rx_op;    // Other opcodes are dropped while running
            if (rx_op == DBG_BRK)
            begin
              state    <= DECODE;
              in_break <= 1'b1;
            end
            else if (rx_op == QUERY_DBG_BRK)
            begin
              cmd_go <= 1'b1;
              state  <= WAIT;
            end
          end
        DECODE:
          if (rd_en)
          begin
            cmd_q.op <= rx_op;
            hdr_idx  <= 2'd0;
            hdr_last <= 2'd3;
            case (rx_op)
              ECHO:
              begin
                hdr_idx <= 2'd2;  // Count only
                state   <= HDR;
              end
              CPU_MEM_RD, CPU_MEM_WR: state <= HDR;
              CPU_REG_RD, CPU_REG_WR:
              begin
                hdr_last  <= 2'd0;   // Select byte only
                cmd_q.cnt <= 16'd1;  // Register write carries one data byte
                state     <= HDR;
              end
              DBG_BRK: state <= DECODE;  // Already halted
              DBG_RUN:
              begin
                state    <= RUN;
                in_break <= 1'b0;
              end
              QUERY_DBG_BRK, QUERY_ERR_CODE:
              begin
                cmd_go <= 1'b1;
                state  <= WAIT;
              end
              default: err_unknown <= 1'b1;  // Sticky
            endcase
          end
        HDR:
          if (rd_en)
          begin
            case (hdr_idx)
              2'd0:    cmd_q.addr[7:0]  <= rx_data;
              2'd1:    cmd_q.addr[15:8] <= rx_data;
              2'd2:    cmd_q.cnt[7:0]   <= rx_data;
              default: cmd_q.cnt[15:8]  <= rx_data;
            endcase
            hdr_idx <= hdr_idx + 2'd1;
            if (hdr_idx == hdr_last)
            begin
              pl_left <= hdr_cnt;
              if (cmd_q.op == CPU_REG_RD)
              begin
                cmd_go <= 1'b1;
                state  <= WAIT;
              end
              else if (hdr_cnt == 16'd0)
                state <= DECODE;  // Empty transfer, nothing issued
              else
              begin
                cmd_go <= 1'b1;
                state  <= (cmd_q.op == CPU_MEM_RD) ? WAIT : PAYLOAD;
              end
            end
          end
        PAYLOAD:
          if (rd_en)
          begin
            pl_left <= pl_left - 16'd1;
            if (pl_left == 16'd1)
              state <= DECODE;
          end
        WAIT:
          if (bus_done || reply_done)
            state <= in_break ? DECODE : RUN;  // Queries may come from RUN
      endcase
    end
  end

endmodule

//--- hw/dbg_bus_seq.sv
// CPU memory bursts; two cycles per read byte, addresses wrap at 64 KiB, cmd is sampled only on cmd_go
module dbg_bus_seq
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_go,
  input  dbg_pkg::dbg_cmd_t cmd,
  input  logic              pl_valid,
  input  logic [7:0]        pl_data,
  output logic              pl_take,
  input  logic              tx_ready,
  output dbg_pkg::tx_req_t  tx_req,
  input  logic [7:0]        cpu_din,
  output dbg_pkg::cpu_bus_t cpu_bus,
  output logic              done
);
  import dbg_pkg::*;

  logic [15:0] addr;
  logic [15:0] rd_left;   // Read bytes still owed
  logic        rd_act;
  logic        sample;    // Low in the address cycle, high in the sample cycle
  logic        wr_act;
  logic        rd_fire;   // Read byte leaves this cycle

  assign rd_fire = rd_act && sample && tx_ready;
  assign pl_take = wr_act && pl_valid;           // Memory takes a byte every cycle
  assign done    = rd_fire && (rd_left == 16'd1);

  always_comb
  begin
    tx_req.valid = rd_fire;
    tx_req.data  = cpu_din;   // Data settled during the address cycle
    cpu_bus.addr = addr;
    cpu_bus.r_nw = !pl_take;  // Write strobe per payload byte
    cpu_bus.dout = pl_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr   <= 16'h0000;
      rd_act <= 1'b0;
      wr_act <= 1'b0;
      sample <= 1'b0;
    end
    else if (cmd_go)
    begin
      rd_act  <= (cmd.op == CPU_MEM_RD) && (cmd.cnt != 16'd0);
      wr_act  <= (cmd.op == CPU_MEM_WR);
      sample  <= 1'b0;
      rd_left <= cmd.cnt;
      if (cmd.op inside {CPU_MEM_RD, CPU_MEM_WR})
        addr <= cmd.addr;
    end
    else if (rd_act)
    begin
      if (!sample)
        sample <= 1'b1;
      else if (tx_ready)      // Stall here under back-pressure
      begin
        sample  <= 1'b0;
        addr    <= addr + 16'd1;
        rd_left <= rd_left - 16'd1;
        if (rd_left == 16'd1)
          rd_act <= 1'b0;
      end
    end
    else if (pl_take)
      addr <= addr + 16'd1;
  end

endmodule

//--- hw/dbg_reply_unit.sv
// Echo, register access and status replies; one reply in flight, register select uses 4 bits
module dbg_reply_unit
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_go,
  input  dbg_pkg::dbg_cmd_t cmd,
  input  logic              pl_valid,
  input  logic [7:0]        pl_data,
  output logic              pl_take,
  input  logic              tx_ready,
  output dbg_pkg::tx_req_t  tx_req,
  input  logic              in_break,
  input  logic [7:0]        err_code,
  input  logic [7:0]        cpu_dbgreg_in,
  output dbg_pkg::dbgreg_t  dbgreg,
  output logic              done
);
  import dbg_pkg::*;

  dbg_op_e    op;          // Last command issued
  logic [3:0] sel;
  logic       pend;        // Single reply byte owed
  logic       echo;
  logic       reg_wr;
  logic [7:0] reply_byte;

  assign echo    = (op == ECHO);
  assign reg_wr  = (op == CPU_REG_WR);
  assign pl_take = pl_valid && (reg_wr || (echo && tx_ready));  // Echo needs room to reply
  assign done    = pend && tx_ready;

  always_comb
  begin
    case (op)
      CPU_REG_RD:    reply_byte = cpu_dbgreg_in;
      QUERY_DBG_BRK: reply_byte = {7'd0, in_break};
      default:       reply_byte = err_code;
    endcase
    tx_req.valid = done || (echo && pl_take);
    tx_req.data  = echo ? pl_data : reply_byte;
    dbgreg.sel   = sel;
    dbgreg.wr    = reg_wr && pl_take;
    dbgreg.dout  = pl_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      op   <= DBG_RUN;  // Owns no payload
      sel  <= 4'd0;
      pend <= 1'b0;
    end
    else if (cmd_go)
    begin
      op   <= cmd.op;
      sel  <= cmd.addr[3:0];
      pend <= cmd.op inside {CPU_REG_RD, QUERY_DBG_BRK, QUERY_ERR_CODE};
    end
    else if (done)
      pend <= 1'b0;
  end

endmodule

//--- hw/dbg_tx_merge.sv
// Expects at most one valid request per cycle; pushes at most every other cycle
module dbg_tx_merge
(
  input  logic             clk,
  input  logic             rst,
  input  dbg_pkg::tx_req_t bus_req,
  input  dbg_pkg::tx_req_t reply_req,
  input  logic             tx_full,
  output logic             tx_ready,
  output logic [7:0]       tx_data,
  output logic             wr_en
);
  import dbg_pkg::*;

  tx_req_t req;  // Selected request

  always_comb
  begin
    req = bus_req.valid ? bus_req : reply_req;  // Engines never overlap
  end

  // tx_full does not yet count a push still in the register
  assign tx_ready = !tx_full && !wr_en;

  always_ff @(posedge clk)
  begin
    if (rst)
      wr_en <= 1'b0;
    else
      wr_en <= req.valid && tx_ready;
  end

  always_ff @(posedge clk)
  begin
    if (req.valid)
      tx_data <= req.data;
  end

endmodule

//--- hw/dbg_top.sv
// Debug engine top; receive and transmit FIFOs sit outside, cpu_din and cpu_dbgreg_in are combinational
module dbg_top
(
  input  logic              clk,
  input  logic              rst,
  input  logic [7:0]        rx_data,
  input  logic              rx_empty,
  output logic              rd_en,
  output logic [7:0]        tx_data,
  output logic              wr_en,
  input  logic              tx_full,
  input  logic              brk,
  input  logic [7:0]        cpu_din,
  output dbg_pkg::cpu_bus_t cpu_bus,
  output logic              cpu_ready,
  input  logic [7:0]        cpu_dbgreg_in,
  output dbg_pkg::dbgreg_t  dbgreg
);
  import dbg_pkg::*;

  dbg_cmd_t   cmd;
  logic       cmd_go;
  logic       pl_valid;
  logic [7:0] pl_data;
  logic       bus_take;
  logic       reply_take;
  logic       bus_done;
  logic       reply_done;
  logic       in_break;
  logic [7:0] err_code;
  logic       tx_ready;
  tx_req_t    bus_req;
  tx_req_t    reply_req;

  assign cpu_ready = ~in_break;  // CPU halts during a debug break

  ////////////////////////////////////////////////////////////////////////////
  // Parser, engines, transmit merge
  ////////////////////////////////////////////////////////////////////////////

  dbg_frontend frontend_i
  (
    .clk(clk), .rst(rst), .rx_data(rx_data), .rx_empty(rx_empty), .rd_en(rd_en),
    .brk(brk), .cmd_go(cmd_go), .cmd(cmd), .pl_valid(pl_valid), .pl_data(pl_data),
    .pl_take(bus_take | reply_take),  // Only the owning engine takes
    .bus_done(bus_done), .reply_done(reply_done), .in_break(in_break), .err_code(err_code)
  );

  dbg_bus_seq bus_seq_i
  (
    .clk(clk), .rst(rst), .cmd_go(cmd_go), .cmd(cmd), .pl_valid(pl_valid),
    .pl_data(pl_data), .pl_take(bus_take), .tx_ready(tx_ready), .tx_req(bus_req),
    .cpu_din(cpu_din), .cpu_bus(cpu_bus), .done(bus_done)
  );

  dbg_reply_unit reply_unit_i
  (
    .clk(clk), .rst(rst), .cmd_go(cmd_go), .cmd(cmd), .pl_valid(pl_valid),
    .pl_data(pl_data), .pl_take(reply_take), .tx_ready(tx_ready), .tx_req(reply_req),
    .in_break(in_break), .err_code(err_code), .cpu_dbgreg_in(cpu_dbgreg_in),
    .dbgreg(dbgreg), .done(reply_done)
  );

  dbg_tx_merge tx_merge_i
  (
    .clk(clk), .rst(rst), .bus_req(bus_req), .reply_req(reply_req), .tx_full(tx_full),
    .tx_ready(tx_ready), .tx_data(tx_data), .wr_en(wr_en)
  );

endmodule

//--- test/dbg_chk.sv
// Port rules of dbg_top, checked on rising edges outside reset only
module dbg_chk
(
  input logic              clk,
  input logic              rst,
  input logic              rx_empty,
  input logic              rd_en,
  input logic              tx_full,
  input logic              wr_en,
  input dbg_pkg::cpu_bus_t cpu_bus,
  input logic              cpu_ready,
  input dbg_pkg::dbgreg_t  dbgreg
);

  // Never pop an empty receive FIFO
  rd_on_empty: assert property (@(posedge clk) disable iff (rst) rx_empty |-> !rd_en)
    else $error("rd_en high while rx_empty is high");

  // Push follows a cycle with room only
  wr_after_full: assert property (@(posedge clk) disable iff (rst) $past(tx_full) |-> !wr_en)
    else $error("wr_en high one cycle after tx_full");

  mem_wr_in_break: assert property (@(posedge clk) disable iff (rst)
    !cpu_bus.r_nw |-> !cpu_ready)
    else $error("CPU bus write while the CPU runs");

  reg_wr_in_break: assert property (@(posedge clk) disable iff (rst)
    dbgreg.wr |-> !cpu_ready)   // Debug registers change only when halted
    else $error("Debug register write while the CPU runs");

endmodule

bind dbg_top dbg_chk chk_i
(
  .clk(clk), .rst(rst), .rx_empty(rx_empty), .rd_en(rd_en), .tx_full(tx_full),
  .wr_en(wr_en), .cpu_bus(cpu_bus), .cpu_ready(cpu_ready), .dbgreg(dbgreg)
);

//--- test/dbg_tb.sv
// Run from the project root; cases in test/dbg_cases.txt run in order and share one byte stream
module dbg_tb;
  import dbg_pkg::*;

  localparam int TIMEOUT = 2000;  // Cycles allowed per case

  logic       clk;
  logic       rst;
  logic [7:0] rx_data = 8'h00;
  logic       rx_empty = 1'b1;
  logic       rd_en;
  logic [7:0] tx_data;
  logic       wr_en;
  logic       tx_full = 1'b0;
  logic       brk;
  logic [7:0] cpu_din;
  cpu_bus_t   cpu_bus;
  logic       cpu_ready;
  logic [7:0] cpu_dbgreg_in;
  dbgreg_t    dbgreg;

  logic [7:0] mem [0:65535];  // CPU memory
  logic [7:0] regs [0:15];    // CPU debug registers
  logic [7:0] rx_q [$];       // Bytes handed to the receive FIFO
  int         rx_rd = 0;      // Receive FIFO read pointer
  logic [7:0] tx_q [$];       // Every byte the DUT pushed
  int         tx_base = 0;    // First reply byte of the current case
  int         fd;
  int         errors = 0;
  int         checks = 0;
  string      case_name;
  logic [7:0] in_q [$];
  logic [7:0] exp_q [$];

  assign cpu_din       = mem[cpu_bus.addr];  // Combinational read
  assign cpu_dbgreg_in = regs[dbgreg.sel];

  dbg_top dbg_top_i
  (
    .clk(clk), .rst(rst), .rx_data(rx_data), .rx_empty(rx_empty), .rd_en(rd_en),
    .tx_data(tx_data), .wr_en(wr_en), .tx_full(tx_full), .brk(brk), .cpu_din(cpu_din),
    .cpu_bus(cpu_bus), .cpu_ready(cpu_ready), .cpu_dbgreg_in(cpu_dbgreg_in), .dbgreg(dbgreg)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // FIFO, memory and register models
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : bus_model
    logic [31:0] seed;
    logic        pop;
    logic        push;
    logic [7:0]  push_byte;
    logic        mem_we;
    cpu_bus_t    bus_s;
    logic        reg_we;
    dbgreg_t     reg_s;
    seed   = 32'h7eec_f4c6;
    pop    = 1'b0;
    push   = 1'b0;
    mem_we = 1'b0;
    reg_we = 1'b0;
    for (int a = 0; a < 65536; a++)
      mem[a[15:0]] = a[7:0] ^ a[15:8];  // Fill depends on both address bytes
    for (int i = 0; i < 16; i++)
      regs[i[3:0]] = {4'ha, i[3:0]};
    forever
    begin
      @(posedge clk);
      #1;
      if (pop && rx_rd < rx_q.size())
        rx_rd++;
      if (push)
        tx_q.push_back(push_byte);
      if (mem_we)
        mem[bus_s.addr] = bus_s.dout;
      if (reg_we)
        regs[reg_s.sel] = reg_s.dout;
      rx_empty = (rx_rd >= rx_q.size());
      rx_data  = rx_empty ? 8'h00 : rx_q[rx_rd];
      seed     = lcg_next(seed);
      tx_full  = (seed[31:30] == 2'b00);  // Full about a quarter of the time
      @(negedge clk);                     // Strobes settled here
      pop       = rd_en && !rst;
      push      = wr_en && !rst;
      push_byte = tx_data;
      mem_we    = !cpu_bus.r_nw && !rst;
      bus_s     = cpu_bus;
      reg_we    = dbgreg.wr && !rst;
      reg_s     = dbgreg;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Case reader and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_case(output bit ok);
    string tok;
    int    n;
    int    cnt;
    int    v;
    int    c;
    ok = 1'b0;
    in_q.delete();
    exp_q.delete();
    n = $fscanf(fd, "%s", tok);
    while (n == 1 && tok.getc(0) == 8'h23)  // Comment line, skip to newline
    begin
      c = $fgetc(fd);
      while (c != 10 && c != -1)
        c = $fgetc(fd);
      n = $fscanf(fd, "%s", tok);
    end
    if (n != 1)
      return;
    case_name = tok;
    ok = ($fscanf(fd, "%d", cnt) == 1);
    for (int i = 0; ok && i < cnt; i++)
    begin
      ok = ($fscanf(fd, "%h", v) == 1);
      in_q.push_back(v[7:0]);
    end
    if (ok)
      ok = ($fscanf(fd, "%d", cnt) == 1);
    for (int i = 0; ok && i < cnt; i++)
    begin
      ok = ($fscanf(fd, "%h", v) == 1);
      exp_q.push_back(v[7:0]);
    end
    if (!ok)
    begin
      $display("Malformed line in the case file at case %s", case_name);
      errors++;
    end
  endtask

  task automatic pulse_brk();
    @(posedge clk);
    #1 brk = 1'b1;
    @(posedge clk);
    #1 brk = 1'b0;
  endtask

  task automatic run_case(output bit timed_out);
    int t;
    int n_exp;
    n_exp     = exp_q.size();
    timed_out = 1'b0;
    if (tx_q.size() > tx_base)  // Stray bytes after the last case
    begin
      $display("%0d unexpected reply bytes before case %s", tx_q.size() - tx_base, case_name);
      errors++;
      tx_base = tx_q.size();
    end
    if (case_name.substr(0, 3) == "brk_")
      pulse_brk();
    @(negedge clk);
    foreach (in_q[i])
      rx_q.push_back(in_q[i]);
    t = 0;
    while ((rx_rd < rx_q.size() || tx_q.size() < tx_base + n_exp) && t < TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    if (t >= TIMEOUT)
    begin
      $display("Case %s timed out, %0d input bytes left, %0d of %0d replies received",
               case_name, rx_q.size() - rx_rd, tx_q.size() - tx_base, n_exp);
      errors++;
      timed_out = 1'b1;
      return;
    end
    for (int i = 0; i < n_exp; i++)
    begin
      checks++;
      if (tx_q[tx_base + i] !== exp_q[i])
      begin
        $display("[FAIL] %s byte %0d: expected %02h, actual %02h",
                 case_name, i, exp_q[i], tx_q[tx_base + i]);
        errors++;
      end
    end
    // A break query reply of 01 means the CPU is held
    if (n_exp > 0 && in_q[in_q.size() - 1] == QUERY_DBG_BRK)
    begin
      checks++;
      if (cpu_ready !== (exp_q[n_exp - 1] != 8'h01))
      begin
        $display("[FAIL] %s cpu_ready: expected %0b, actual %0b",
                 case_name, exp_q[n_exp - 1] != 8'h01, cpu_ready);
        errors++;
      end
    end
    tx_base += n_exp;
  endtask

  initial
  begin : main
    bit ok;
    bit stop;
    int n_cases;
    stop    = 1'b0;
    n_cases = 0;
    rst     = 1'b1;
    brk     = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    fd = $fopen("test/dbg_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open test/dbg_cases.txt");
      errors++;
    end
    else
    begin
      read_case(ok);
      while (ok && !stop)
      begin
        run_case(stop);
        n_cases++;
        if (!stop)
          read_case(ok);
      end
      $fclose(fd);
      if (!stop)
      begin
        repeat (16) @(negedge clk);  // Room for a stray byte
        if (tx_q.size() > tx_base)
        begin
          $display("%0d unexpected reply bytes after the last case", tx_q.size() - tx_base);
          errors++;
        end
      end
    end
    if (n_cases == 0)
    begin
      $display("No cases were run");
      errors++;
    end
    $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- all.f
hw/dbg_pkg.sv
hw/dbg_frontend.sv
hw/dbg_bus_seq.sv
hw/dbg_reply_unit.sv
hw/dbg_tx_merge.sv
hw/dbg_top.sv
test/dbg_chk.sv
test/dbg_tb.sv

//--- Makefile
# Verilator flow for the debug command engine; every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= dbg_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
	  echo "Simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/dbg_cases.txt
# name  n_in  input bytes (hex)  n_exp  expected reply bytes (hex)
# Counts are decimal; a name starting with brk_ pulses brk before its bytes are sent
query_reset   1  07                                         1  00
halt          1  03                                         0
query_halted  1  07                                         1  01
err_clear     1  08                                         1  00
echo_short    6  00 03 00 a5 5a c3                          3  a5 5a c3
echo_long     13 00 0a 00 01 23 45 67 89 ab cd ef fe dc     10 01 23 45 67 89 ab cd ef fe dc
mem_wr        11 02 00 10 06 00 11 22 33 44 55 66           0
mem_rd        5  01 00 10 06 00                             6  11 22 33 44 55 66
mem_rd_fill   5  01 34 12 02 00                             2  26 27
mem_rd_empty  6  01 00 10 00 00 07                          1  01
mem_wr_wrap   7  02 ff ff 02 00 de ad                       0
mem_rd_wrap   5  01 ff ff 02 00                             2  de ad
reg_wr        3  06 05 9c                                   0
reg_rd        2  05 05                                      1  9c
reg_rd_init   2  05 0b                                      1  ab
bad_op        1  3c                                         0
err_query     1  08                                         1  02
resume        2  04 07                                      1  00
brk_query     1  07                                         1  01
brk_resume    2  04 07                                      1  00
run_drop      2  05 07                                      1  00
